//--- eth_rx_10g_lite.f
source/eth_rx_pkg.sv
source/rx_block_if.sv
source/rx_beat_if.sv
source/rx_block_lock.sv
source/rx_block_decode.sv
source/rx_frame_assemble.sv
source/rx_frame_fifo.sv
source/eth_rx_10g_lite.sv
test/tb_eth_rx_10g_lite.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eth_rx_10g_lite
FILELIST  ?= eth_rx_10g_lite.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_eth_rx_10g_lite.sv
// Frames carry 7 to 40 bytes since a start block always holds 7; assumes fifo_depth 16, lock at 64
module tb_eth_rx_10g_lite;
    timeunit 1ns;
    timeprecision 1ps;

    import eth_rx_pkg::*;

    localparam int fifo_depth = 16;
    localparam int wait_limit = 2000;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [keep_width-1:0] keep;
        logic                  last;
        logic                  user;
    } beat_t;

    logic                  logic_clk;
    logic                  logic_rst;
    logic [data_width-1:0] serdes_rx_data;
    logic [hdr_width-1:0]  serdes_rx_hdr;
    logic                  serdes_rx_bitslip;
    logic [data_width-1:0] rx_axis_tdata;
    logic [keep_width-1:0] rx_axis_tkeep;
    logic                  rx_axis_tvalid;
    logic                  rx_axis_tready;
    logic                  rx_axis_tlast;
    logic                  rx_axis_tuser;
    logic                  rx_block_lock;
    logic                  rx_bad_block;
    logic                  rx_fifo_overflow;
    logic                  rx_fifo_good_frame;
    logic                  rx_fifo_bad_frame;

    // Expected output beats, oldest first
    beat_t exp_q[$];
    beat_t out_beat;
    beat_t stall_beat;
    logic  stall_seen = 1'b0;
    // 0 random tready, 1 tready held low
    int    ready_mode = 0;

    int cnt_bitslip = 0;
    int cnt_bad_block = 0;
    int cnt_good = 0;
    int cnt_bad = 0;
    int cnt_overflow = 0;
    int exp_bad_block = 0;
    int exp_good = 0;
    int exp_bad = 0;
    int exp_overflow = 0;
    int err_beat = 0;
    int err_status = 0;
    int err_other = 0;

    eth_rx_10g_lite #(
        .fifo_depth(fifo_depth)
    ) eth_rx_10g_lite_i (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .serdes_rx_data    (serdes_rx_data),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .rx_axis_tdata     (rx_axis_tdata),
        .rx_axis_tkeep     (rx_axis_tkeep),
        .rx_axis_tvalid    (rx_axis_tvalid),
        .rx_axis_tready    (rx_axis_tready),
        .rx_axis_tlast     (rx_axis_tlast),
        .rx_axis_tuser     (rx_axis_tuser),
        .rx_block_lock     (rx_block_lock),
        .rx_bad_block      (rx_bad_block),
        .rx_fifo_overflow  (rx_fifo_overflow),
        .rx_fifo_good_frame(rx_fifo_good_frame),
        .rx_fifo_bad_frame (rx_fifo_bad_frame)
    );

    assign out_beat = {rx_axis_tdata, rx_axis_tkeep, rx_axis_tlast, rx_axis_tuser};

    initial begin
        logic_clk = 1'b0;
        forever #20 logic_clk = ~logic_clk;
    end

    task automatic check_beat(input beat_t exp, input beat_t got);
        if (got.data !== exp.data) begin
            $display("ERROR rx_axis_tdata exp %h got %h", exp.data, got.data);
            err_beat++;
        end
        if (got.keep !== exp.keep) begin
            $display("ERROR rx_axis_tkeep exp %h got %h", exp.keep, got.keep);
            err_beat++;
        end
        if (got.last !== exp.last) begin
            $display("ERROR rx_axis_tlast exp %h got %h", exp.last, got.last);
            err_beat++;
        end
        if (got.user !== exp.user) begin
            $display("ERROR rx_axis_tuser exp %h got %h", exp.user, got.user);
            err_beat++;
        end
    endtask

    task automatic check_status(input string name, input int exp, input int got);
        if (got != exp) begin
            $display("ERROR %s exp %h got %h", name, exp, got);
            err_status++;
        end
    endtask

    // Output side: pulse counters, stall hold and in-order beat compare
    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            cnt_bitslip   += int'(serdes_rx_bitslip);
            cnt_bad_block += int'(rx_bad_block);
            cnt_good      += int'(rx_fifo_good_frame);
            cnt_bad       += int'(rx_fifo_bad_frame);
            cnt_overflow  += int'(rx_fifo_overflow);
            if (rx_block_lock && serdes_rx_bitslip) begin
                $display("ERROR serdes_rx_bitslip exp %h got %h", 1'b0, serdes_rx_bitslip);
                err_other++;
            end
            if (stall_seen) begin
                if (!rx_axis_tvalid) begin
                    $display("Output beat was withdrawn while tready was low");
                    err_other++;
                end else begin
                    check_beat(stall_beat, out_beat);
                end
            end
            stall_seen = rx_axis_tvalid && !rx_axis_tready;
            stall_beat = out_beat;
            if (rx_axis_tvalid && rx_axis_tready) begin
                if (exp_q.size() == 0) begin
                    $display("Output beat arrived while no beat was expected");
                    err_other++;
                end else begin
                    check_beat(exp_q.pop_front(), out_beat);
                end
            end
        end
    end

    function automatic rx_block_u ctrl_word(input logic [7:0] btype, input logic [55:0] payload);
        rx_block_u w;
        w.ctrl.btype   = btype;
        w.ctrl.payload = payload;
        return w;
    endfunction

    function automatic logic [7:0] term_type(input int n);
        case (n)
            0: return bt_term0;
            1: return bt_term1;
            2: return bt_term2;
            3: return bt_term3;
            4: return bt_term4;
            5: return bt_term5;
            6: return bt_term6;
            default: return bt_term7;
        endcase
    endfunction

    // Start beat, one beat per data block, plus a tail beat when the terminate has bytes
    function automatic int frame_beats(input int len);
        return 1 + (len - 7) / 8 + ((((len - 7) % 8) != 0) ? 1 : 0);
    endfunction

    task automatic send_block(input logic [hdr_width-1:0] hdr, input rx_block_u word);
        @(posedge logic_clk);
        #2;
        serdes_rx_hdr  = hdr;
        serdes_rx_data = word;
        rx_axis_tready = (ready_mode == 0) ? ($urandom_range(7, 0) != 0) : 1'b0;
    endtask

    task automatic send_idle();
        send_block(hdr_ctrl, ctrl_word(bt_idle, '0));
    endtask

    // An aborted frame stops after some data blocks; the caller follows it with a start
    task automatic send_frame(input int len, input bit abort, input bit deliver);
        int          ndata;
        int          ntail;
        int          nsent;
        logic [55:0] payload;
        logic [63:0] word;
        beat_t       held;
        beat_t       tail;
        beat_t       frame_q[$];
        ndata   = (len - 7) / 8;
        ntail   = (len - 7) % 8;
        nsent   = abort ? int'($urandom_range(ndata, 0)) : ndata;
        payload = 56'({$urandom(), $urandom()});
        send_block(hdr_ctrl, ctrl_word(bt_start, payload));
        held = '{data: {8'h00, payload}, keep: 8'h7f, last: 1'b0, user: 1'b0};
        for (int i = 0; i < nsent; i++) begin
            word = {$urandom(), $urandom()};
            send_block(hdr_data, word);
            frame_q.push_back(held);
            held = '{data: word, keep: 8'hff, last: 1'b0, user: 1'b0};
        end
        if (abort) begin
            held.last = 1'b1;
            held.user = 1'b1;
            frame_q.push_back(held);
        end else begin
            // Unused terminate lanes are sent as zero
            payload = 56'({$urandom(), $urandom()}) & ((56'd1 << (8 * ntail)) - 56'd1);
            send_block(hdr_ctrl, ctrl_word(term_type(ntail), payload));
            held.last = (ntail == 0);
            frame_q.push_back(held);
            if (ntail != 0) begin
                tail.data = {8'h00, payload};
                // One enable per carried byte, from lane 0 up
                tail.keep = '0;
                for (int b = 0; b < ntail; b++) begin
                    tail.keep[b] = 1'b1;
                end
                tail.last = 1'b1;
                tail.user = 1'b0;
                frame_q.push_back(tail);
            end
        end
        if (deliver) begin
            foreach (frame_q[i]) exp_q.push_back(frame_q[i]);
        end
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < wait_limit) begin
            send_idle();
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout with %0d expected beats never delivered", exp_q.size());
            err_other++;
            exp_q.delete();
        end
    endtask

    initial begin
        int n_bad_hdr;
        int waited;
        int len;
        int used;
        int offered;
        void'($urandom(32'hacf810ca));
        logic_rst      = 1'b1;
        serdes_rx_data = '0;
        serdes_rx_hdr  = hdr_ctrl;
        rx_axis_tready = 1'b0;
        repeat (10) @(posedge logic_clk);
        #2;
        logic_rst = 1'b0;

        // Short valid runs broken by bad headers, never 64 in a row
        n_bad_hdr = 3 + int'($urandom_range(3, 0));
        for (int i = 0; i < n_bad_hdr; i++) begin
            repeat ($urandom_range(20, 0)) send_idle();
            send_block(($urandom_range(1, 0) != 0) ? 2'b11 : 2'b00, ctrl_word(bt_idle, '0));
        end
        for (int i = 0; i < 64; i++) begin
            send_idle();
            if (rx_block_lock) begin
                $display("Block lock rose after only %0d valid headers", i);
                err_other++;
            end
        end
        waited = 0;
        while (!rx_block_lock && waited < 8) begin
            send_idle();
            waited++;
        end
        if (!rx_block_lock) begin
            $display("Timeout waiting for block lock");
            err_other++;
        end
        check_status("serdes_rx_bitslip", n_bad_hdr, cnt_bitslip);

        // Random frames, aborts and unknown block types with random tready
        ready_mode = 0;
        for (int f = 0; f < 40; f++) begin
            len = 7 + int'($urandom_range(33, 0));
            if ($urandom_range(5, 0) == 0) begin
                send_frame(len, 1'b1, 1'b1);
                exp_bad++;
            end else begin
                send_frame(len, 1'b0, 1'b1);
                exp_good++;
                if ($urandom_range(4, 0) == 0) begin
                    send_block(hdr_ctrl, ctrl_word(8'h2d, '0));
                    exp_bad_block++;
                end
                // Bad header while locked, far below the unlock limit
                if (f % 8 == 3) begin
                    send_block(2'b11, ctrl_word(bt_idle, '0));
                    exp_bad_block++;
                end
                repeat (2 + $urandom_range(3, 0)) send_idle();
            end
        end
        send_frame(7 + int'($urandom_range(33, 0)), 1'b0, 1'b1);
        exp_good++;
        drain_queue();
        check_status("rx_fifo_good_frame", exp_good, cnt_good);
        check_status("rx_fifo_bad_frame", exp_bad, cnt_bad);
        check_status("rx_bad_block", exp_bad_block, cnt_bad_block);
        check_status("serdes_rx_bitslip", n_bad_hdr, cnt_bitslip);
        if (!rx_block_lock) begin
            $display("Block lock dropped after a few bad headers");
            err_other++;
        end

        // Stalled output; the output register holds one beat beyond the FIFO memory
        ready_mode = 1;
        used       = 0;
        offered    = 0;
        while (offered <= fifo_depth + 1) begin
            len = 7 + int'($urandom_range(33, 0));
            if (used + frame_beats(len) <= fifo_depth + 1) begin
                send_frame(len, 1'b0, 1'b1);
                used += frame_beats(len);
                exp_good++;
            end else begin
                send_frame(len, 1'b0, 1'b0);
                exp_overflow++;
            end
            offered += frame_beats(len);
            repeat (2) send_idle();
        end
        ready_mode = 0;
        drain_queue();
        check_status("rx_fifo_good_frame", exp_good, cnt_good);
        check_status("rx_fifo_bad_frame", exp_bad, cnt_bad);
        check_status("rx_fifo_overflow", exp_overflow, cnt_overflow);

        $display("Errors: beat %0d, status %0d, other %0d", err_beat, err_status, err_other);
        if (err_beat + err_status + err_other == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- source/eth_rx_10g_lite.sv
// Receive only, one clock; no descrambler, FCS check or BER monitor, so inputs arrive unscrambled
module eth_rx_10g_lite #(
    parameter int fifo_depth      = 64,
    parameter int lock_good_count = 64,
    parameter int lock_bad_limit  = 16,
    parameter int lock_window     = 1024
) (
    input  logic                              logic_clk,
    input  logic                              logic_rst,
    input  logic [eth_rx_pkg::data_width-1:0] serdes_rx_data,
    input  logic [eth_rx_pkg::hdr_width-1:0]  serdes_rx_hdr,
    output logic                              serdes_rx_bitslip,
    output logic [eth_rx_pkg::data_width-1:0] rx_axis_tdata,
    output logic [eth_rx_pkg::keep_width-1:0] rx_axis_tkeep,
    output logic                              rx_axis_tvalid,
    input  logic                              rx_axis_tready,
    output logic                              rx_axis_tlast,
    output logic                              rx_axis_tuser,
    output logic                              rx_block_lock,
    output logic                              rx_bad_block,
    output logic                              rx_fifo_overflow,
    output logic                              rx_fifo_good_frame,
    output logic                              rx_fifo_bad_frame
);

    rx_block_if blk_if ();
    rx_beat_if  beat_if ();

    rx_block_lock #(
        .lock_good_count(lock_good_count),
        .lock_bad_limit (lock_bad_limit),
        .lock_window    (lock_window)
    ) block_lock_i (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .serdes_rx_hdr(serdes_rx_hdr),
        .block_lock   (rx_block_lock),
        .bitslip      (serdes_rx_bitslip)
    );

    rx_block_decode block_decode_i (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .serdes_rx_data(serdes_rx_data),
        .serdes_rx_hdr (serdes_rx_hdr),
        .block_lock    (rx_block_lock),
        .blk           (blk_if.decoder),
        .bad_block     (rx_bad_block)
    );

    rx_frame_assemble frame_assemble_i (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .blk      (blk_if.assembler),
        .beat     (beat_if.assembler)
    );

    rx_frame_fifo #(
        .depth(fifo_depth)
    ) frame_fifo_i (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .beat      (beat_if.fifo),
        .m_tdata   (rx_axis_tdata),
        .m_tkeep   (rx_axis_tkeep),
        .m_tvalid  (rx_axis_tvalid),
        .m_tready  (rx_axis_tready),
        .m_tlast   (rx_axis_tlast),
        .m_tuser   (rx_axis_tuser),
        .overflow  (rx_fifo_overflow),
        .good_frame(rx_fifo_good_frame),
        .bad_frame (rx_fifo_bad_frame)
    );

endmodule

//--- source/rx_frame_fifo.sv
// depth must be a power of two; a frame longer than depth is always dropped
module rx_frame_fifo #(
    parameter int depth = 64
) (
    input  logic                              logic_clk,
    input  logic                              logic_rst,
    rx_beat_if.fifo                           beat,
    output logic [eth_rx_pkg::data_width-1:0] m_tdata,
    output logic [eth_rx_pkg::keep_width-1:0] m_tkeep,
    output logic                              m_tvalid,
    input  logic                              m_tready,
    output logic                              m_tlast,
    output logic                              m_tuser,
    output logic                              overflow,
    output logic                              good_frame,
    output logic                              bad_frame
);
    import eth_rx_pkg::*;

    localparam int addr_w = $clog2(depth);
    localparam int word_w = data_width + keep_width + 2;

    logic [word_w-1:0] mem [depth];
    logic [addr_w:0]   wr_ptr;
    logic [addr_w:0]   commit_ptr;
    logic [addr_w:0]   rd_ptr;
    logic              drop_frame;
    logic              full;
    logic              wr_en;
    logic              rd_en;

    // Full against the read side, empty against committed frames only
    assign full  = wr_ptr == {~rd_ptr[addr_w], rd_ptr[addr_w-1:0]};
    assign wr_en = beat.valid && !drop_frame && !full;
    assign rd_en = (rd_ptr != commit_ptr) && (!m_tvalid || m_tready);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            drop_frame <= 1'b0;
            m_tvalid   <= 1'b0;
            overflow   <= 1'b0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
        end else begin
            overflow   <= 1'b0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            if (beat.valid) begin
                if (drop_frame) begin
                    drop_frame <= !beat.last;
                end else if (full) begin
                    // Rewind and discard whatever is left of this frame
                    wr_ptr     <= commit_ptr;
                    drop_frame <= !beat.last;
                    overflow   <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (beat.last) begin
                        commit_ptr <= wr_ptr + 1'b1;
                        good_frame <= !beat.user;
                        bad_frame  <= beat.user;
                    end
                end
            end
            if (rd_en) begin
                rd_ptr   <= rd_ptr + 1'b1;
                m_tvalid <= 1'b1;
            end else if (m_tready) begin
                m_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[addr_w-1:0]] <= {beat.user, beat.last, beat.keep, beat.data};
        end
        if (rd_en) begin
            {m_tuser, m_tlast, m_tkeep, m_tdata} <= mem[rd_ptr[addr_w-1:0]];
        end
    end

    // Stalled output beat holds until taken
    a_out_hold: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable({m_tdata, m_tkeep, m_tlast, m_tuser})
    );

endmodule

//--- source/rx_frame_assemble.sv
// Beats stay low-aligned per block; a start beat carries 7 bytes, no realignment
module rx_frame_assemble (
    input  logic           logic_clk,
    input  logic           logic_rst,
    rx_block_if.assembler  blk,
    rx_beat_if.assembler   beat
);
    import eth_rx_pkg::*;

    logic                  held_valid;
    logic [data_width-1:0] held_data;
    logic [keep_width-1:0] held_keep;
    logic                  tail_valid;
    logic [data_width-1:0] tail_data;
    logic [keep_width-1:0] tail_keep;

    function automatic logic [keep_width-1:0] keep_from_count(input logic [3:0] n);
        logic [keep_width:0] mask;
        mask = ({{keep_width{1'b0}}, 1'b1} << n) - 1'b1;
        return mask[keep_width-1:0];
    endfunction

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            held_valid <= 1'b0;
            tail_valid <= 1'b0;
            beat.valid <= 1'b0;
            beat.last  <= 1'b0;
            beat.user  <= 1'b0;
        end else begin
            beat.valid <= 1'b0;
            beat.last  <= 1'b0;
            beat.user  <= 1'b0;
            tail_valid <= 1'b0;
            if (blk.valid) begin
                case (blk.kind)
                    kind_start: begin
                        // Start inside a frame aborts the held frame
                        beat.valid <= held_valid;
                        beat.last  <= held_valid;
                        beat.user  <= held_valid;
                        held_valid <= 1'b1;
                    end
                    kind_data: begin
                        beat.valid <= held_valid;
                    end
                    kind_term: begin
                        beat.valid <= held_valid;
                        beat.last  <= held_valid && (blk.nbytes == 4'd0);
                        tail_valid <= held_valid && (blk.nbytes != 4'd0);
                        held_valid <= 1'b0;
                    end
                    default: begin
                        beat.valid <= held_valid;
                        beat.last  <= held_valid;
                        beat.user  <= held_valid;
                        held_valid <= 1'b0;
                    end
                endcase
            end
            // Second beat of a terminate with data
            if (tail_valid) begin
                beat.valid <= 1'b1;
                beat.last  <= 1'b1;
            end
        end
    end

    // Payload path
    always_ff @(posedge logic_clk) begin
        if (tail_valid) begin
            beat.data <= tail_data;
            beat.keep <= tail_keep;
        end
        if (blk.valid && held_valid) begin
            beat.data <= held_data;
            beat.keep <= held_keep;
        end
        if (blk.valid) begin
            if (blk.kind == kind_start) begin
                held_data <= {8'h00, blk.data.ctrl.payload};
                held_keep <= keep_from_count(4'd7);
            end else begin
                held_data <= blk.data.bytes;
                held_keep <= keep_from_count(4'd8);
            end
            tail_data <= {8'h00, blk.data.ctrl.payload};
            tail_keep <= keep_from_count(blk.nbytes);
        end
    end

    a_keep_nonzero: assert property (
        @(posedge logic_clk) disable iff (logic_rst) beat.valid |-> beat.keep != '0
    );

endmodule

//--- source/rx_block_decode.sv
// Expects unscrambled blocks; idle payload control codes are not checked
module rx_block_decode (
    input  logic                              logic_clk,
    input  logic                              logic_rst,
    input  logic [eth_rx_pkg::data_width-1:0] serdes_rx_data,
    input  logic [eth_rx_pkg::hdr_width-1:0]  serdes_rx_hdr,
    input  logic                              block_lock,
    rx_block_if.decoder                       blk,
    output logic                              bad_block
);
    import eth_rx_pkg::*;

    rx_block_u  blk_in;
    logic [1:0] next_kind;
    logic [3:0] next_nbytes;
    logic       next_bad;

    assign blk_in = serdes_rx_data;

    always_comb begin
        next_kind   = kind_idle;
        next_nbytes = 4'd0;
        next_bad    = 1'b0;
        if (serdes_rx_hdr == hdr_data) begin
            next_kind   = kind_data;
            next_nbytes = 4'd8;
        end else if (serdes_rx_hdr == hdr_ctrl) begin
            next_kind = kind_term;
            case (blk_in.ctrl.btype)
                bt_idle:  next_kind = kind_idle;
                bt_start: begin
                    next_kind   = kind_start;
                    next_nbytes = 4'd7;
                end
                bt_term0: next_nbytes = 4'd0;
                bt_term1: next_nbytes = 4'd1;
                bt_term2: next_nbytes = 4'd2;
                bt_term3: next_nbytes = 4'd3;
                bt_term4: next_nbytes = 4'd4;
                bt_term5: next_nbytes = 4'd5;
                bt_term6: next_nbytes = 4'd6;
                bt_term7: next_nbytes = 4'd7;
                default: begin
                    // Unknown type falls back to idle
                    next_kind = kind_idle;
                    next_bad  = 1'b1;
                end
            endcase
        end else begin
            next_bad = 1'b1;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            blk.valid <= 1'b0;
            blk.kind  <= kind_idle;
            bad_block <= 1'b0;
        end else begin
            blk.valid <= block_lock;
            blk.kind  <= next_kind;
            bad_block <= block_lock && next_bad;
        end
    end

    always_ff @(posedge logic_clk) begin
        blk.data   <= blk_in;
        blk.nbytes <= next_nbytes;
    end

    // Byte count must fit the assembler keep mask
    a_nbytes_range: assert property (
        @(posedge logic_clk) disable iff (logic_rst) blk.valid |-> blk.nbytes <= 4'd8
    );

endmodule

//--- source/rx_block_lock.sv
// Header-only lock; bitslip is a raw one-cycle request per bad header, no settle delay
module rx_block_lock #(
    parameter int lock_good_count = 64,
    parameter int lock_bad_limit  = 16,
    parameter int lock_window     = 1024
) (
    input  logic                         logic_clk,
    input  logic                         logic_rst,
    input  logic [eth_rx_pkg::hdr_width-1:0] serdes_rx_hdr,
    output logic                         block_lock,
    output logic                         bitslip
);
    import eth_rx_pkg::*;

    localparam int good_w = $clog2(lock_good_count);
    localparam int win_w  = $clog2(lock_window);
    localparam int bad_w  = $clog2(lock_bad_limit + 1);

    logic              hdr_ok;
    logic [good_w-1:0] good_cnt;
    logic [win_w-1:0]  win_cnt;
    logic [bad_w-1:0]  bad_cnt;

    // Only 01 and 10 are legal sync headers
    assign hdr_ok = (serdes_rx_hdr == hdr_data) || (serdes_rx_hdr == hdr_ctrl);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            block_lock <= 1'b0;
            bitslip    <= 1'b0;
            good_cnt   <= '0;
            win_cnt    <= '0;
            bad_cnt    <= '0;
        end else begin
            bitslip <= 1'b0;
            if (!block_lock) begin
                if (!hdr_ok) begin
                    good_cnt <= '0;
                    bitslip  <= 1'b1;
                end else if (good_cnt == good_w'(lock_good_count - 1)) begin
                    block_lock <= 1'b1;
                    good_cnt   <= '0;
                    win_cnt    <= '0;
                    bad_cnt    <= '0;
                end else begin
                    good_cnt <= good_cnt + 1'b1;
                end
            end else begin
                // Bad headers counted per window; too many drops lock
                if (!hdr_ok) begin
                    if (bad_cnt == bad_w'(lock_bad_limit - 1)) begin
                        block_lock <= 1'b0;
                    end else begin
                        bad_cnt <= bad_cnt + 1'b1;
                    end
                end
                if (win_cnt == win_w'(lock_window - 1)) begin
                    win_cnt <= '0;
                    bad_cnt <= '0;
                end else begin
                    win_cnt <= win_cnt + 1'b1;
                end
            end
        end
    end

    // A slip request while locked would shift a good alignment away
    a_no_slip_locked: assert property (
        @(posedge logic_clk) disable iff (logic_rst) block_lock |-> !bitslip
    );

endmodule

//--- source/rx_beat_if.sv
// Framed beats into the frame FIFO; the FIFO side never stalls, it drops instead
interface rx_beat_if;
    import eth_rx_pkg::*;

    logic                  valid;
    logic [data_width-1:0] data;
    logic [keep_width-1:0] keep;
    logic                  last;
    // Set on the last beat of an aborted frame
    logic                  user;

    modport assembler (
        output valid, data, keep, last, user
    );

    modport fifo (
        input valid, data, keep, last, user
    );

endinterface

//--- source/rx_block_if.sv
// Decoded blocks, one per cycle when valid; there is no back-pressure on this path
interface rx_block_if;
    import eth_rx_pkg::*;

    logic       valid;
    logic [1:0] kind;
    rx_block_u  data;
    // Payload byte count, 0 to 8
    logic [3:0] nbytes;

    modport decoder (
        output valid, kind, data, nbytes
    );

    modport assembler (
        input valid, kind, data, nbytes
    );

endinterface

//--- source/eth_rx_pkg.sv
// Single clock, unscrambled 64b/66b blocks only; control blocks carry the block type in byte 0
package eth_rx_pkg;

    // Block and lane widths
    localparam int data_width = 64;
    localparam int hdr_width  = 2;
    localparam int keep_width = data_width / 8;

    // Sync header codes
    localparam logic [hdr_width-1:0] hdr_data = 2'b01;
    localparam logic [hdr_width-1:0] hdr_ctrl = 2'b10;

    // Block types for control blocks
    localparam logic [7:0] bt_idle  = 8'h1e;
    localparam logic [7:0] bt_start = 8'h78;
    localparam logic [7:0] bt_term0 = 8'h87;
    localparam logic [7:0] bt_term1 = 8'h99;
    localparam logic [7:0] bt_term2 = 8'haa;
    localparam logic [7:0] bt_term3 = 8'hb4;
    localparam logic [7:0] bt_term4 = 8'hcc;
    localparam logic [7:0] bt_term5 = 8'hd2;
    localparam logic [7:0] bt_term6 = 8'he1;
    localparam logic [7:0] bt_term7 = 8'hff;

    // Decoded block kinds
    localparam logic [1:0] kind_idle  = 2'd0;
    localparam logic [1:0] kind_start = 2'd1;
    localparam logic [1:0] kind_data  = 2'd2;
    localparam logic [1:0] kind_term  = 2'd3;

    // One block word, read as eight data bytes or as type byte plus seven bytes
    typedef union packed {
        logic [keep_width-1:0][7:0] bytes;
        struct packed {
            logic [keep_width-2:0][7:0] payload;
            logic [7:0]                 btype;
        } ctrl;
    } rx_block_u;

endpackage
